/* verilog/paddle_pkg.sv */
// ------------------------------
// shared types for the paddle chooser
// four slots, four sources of each kind
// mouse packet follows the ps/2 byte layout
// ------------------------------

package paddle_pkg;

	// slots, sources per kind and mask bits
	localparam int NUM_PORTS = 4;
	localparam int PADDLE_W = 8;

	typedef logic [1:0] port_idx_t;
	typedef logic [PADDLE_W-1:0] paddle_t;

	// one analog stick, two's complement axes
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} stick_t;

	// ps/2 packet as presented by the host core
	typedef struct packed {
		logic strobe;       // toggles once per packet
		logic [7:0] gap_hi;
		logic [7:0] dx;
		logic unused_7;
		logic ovf_x;
		logic gap_5;
		logic sign_x;
		logic [2:0] gap_lo;
		logic button;       // left button
	} mouse_pkt_t;

	typedef enum logic [1:0] {
		SRC_SPINNER = 2'd0,
		SRC_ANALOG  = 2'd1,
		SRC_MOUSE   = 2'd2
	} src_kind_t;

	// what a slot has claimed
	typedef struct packed {
		logic active;
		src_kind_t kind;
		port_idx_t idx;
		logic axis_x;   // analog only, x instead of y
		logic alt_btn;  // analog only, second button
	} slot_t;

	typedef slot_t [NUM_PORTS-1:0] slot_array_t;

	// two's complement to offset binary
	function automatic paddle_t to_offset(input logic [PADDLE_W-1:0] v);
		return {~v[PADDLE_W-1], v[PADDLE_W-2:0]};
	endfunction

endpackage

/* verilog/motion_detect.sv */
// ------------------------------
// flags moves to an extreme
// sticks are checked in offset binary
// spinners are already unsigned
// ------------------------------
`timescale 1ns/1ps

module motion_detect (
	input logic clk,
	input paddle_pkg::stick_t [paddle_pkg::NUM_PORTS-1:0] analog,
	input paddle_pkg::paddle_t [paddle_pkg::NUM_PORTS-1:0] paddle,
	output logic [paddle_pkg::NUM_PORTS-1:0] x_sel,
	output logic [paddle_pkg::NUM_PORTS-1:0] y_sel,
	output logic [paddle_pkg::NUM_PORTS-1:0] p_sel
);
	import paddle_pkg::*;

	// current offset values of every stick axis
	paddle_t [NUM_PORTS-1:0] x_cur;
	paddle_t [NUM_PORTS-1:0] y_cur;
	// last cycle's samples
	paddle_t [NUM_PORTS-1:0] x_prev;
	paddle_t [NUM_PORTS-1:0] y_prev;
	paddle_t [NUM_PORTS-1:0] p_prev;

	// changed and now in the top or bottom quarter
	function automatic logic moved_to_end(input paddle_t cur, input paddle_t prev);
		return (cur != prev) &&
			(cur[PADDLE_W-1 -: 2] == 2'b11 || cur[PADDLE_W-1 -: 2] == 2'b00);
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			x_cur[i] = to_offset(analog[i].x);
			y_cur[i] = to_offset(analog[i].y);
		end
	end

	// selects are one cycle wide per detected move
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			x_prev[i] <= x_cur[i];
			y_prev[i] <= y_cur[i];
			p_prev[i] <= paddle[i];
			x_sel[i] <= moved_to_end(x_cur[i], x_prev[i]);
			y_sel[i] <= moved_to_end(y_cur[i], y_prev[i]);
			p_sel[i] <= moved_to_end(paddle[i], p_prev[i]);
		end
	end

endmodule

/* verilog/mouse_tracker.sv */
// ------------------------------
// x motion only, y is ignored
// position wraps at the 8-bit range
// step limit set by MOUSE_STEP_MAX
// ------------------------------
`timescale 1ns/1ps

module mouse_tracker #(
	parameter int MOUSE_STEP_MAX = 64
) (
	input logic clk,
	input logic reset,
	input paddle_pkg::mouse_pkt_t mouse,
	output logic signed [7:0] mouse_pos
);
	import paddle_pkg::*;

	localparam logic signed [8:0] STEP_LIM = 9'(MOUSE_STEP_MAX);

	logic strobe_q;
	logic signed [8:0] dx_raw;
	logic signed [8:0] step;
	logic signed [9:0] sum;

	// 9-bit signed delta as sent by the mouse
	assign dx_raw = {mouse.sign_x, mouse.dx};

	always_comb begin
		// overflow means the mouse moved further than it could report
		if (mouse.ovf_x)
			step = mouse.sign_x ? -STEP_LIM : STEP_LIM;
		else if (dx_raw > STEP_LIM)
			step = STEP_LIM;
		else if (dx_raw < -STEP_LIM)
			step = -STEP_LIM;
		else
			step = dx_raw;
	end

	assign sum = mouse_pos + step;

	always_ff @(posedge clk) begin
		strobe_q <= mouse.strobe;
		if (reset) begin
			mouse_pos <= '0;
		end else if (strobe_q != mouse.strobe) begin
			// wrap instead of saturating, so a spinner-like feel
			if (sum > 10'sd127)
				mouse_pos <= 8'sh80;
			else if (sum < -10'sd128)
				mouse_pos <= 8'sh7f;
			else
				mouse_pos <= sum[7:0];
		end
	end

endmodule

/* verilog/paddle_assigner.sv */
// ------------------------------
// claims last until reset
// one slot claimed per cycle at most
// winner order: mouse, spinner, y, x
// ------------------------------
`timescale 1ns/1ps

module paddle_assigner (
	input logic clk,
	input logic reset,
	input logic [paddle_pkg::NUM_PORTS-1:0] mask,
	input logic use_multi,
	input logic mouse_button,
	input logic [paddle_pkg::NUM_PORTS-1:0] x_sel,
	input logic [paddle_pkg::NUM_PORTS-1:0] y_sel,
	input logic [paddle_pkg::NUM_PORTS-1:0] p_sel,
	output logic [paddle_pkg::NUM_PORTS-1:0] assigned,
	output paddle_pkg::slot_array_t slots,
	output logic stick_x_used
);
	import paddle_pkg::*;

	// sources already taken
	logic [NUM_PORTS-1:0] x_used;
	logic [NUM_PORTS-1:0] y_used;
	logic [NUM_PORTS-1:0] p_used;
	logic mouse_used;

	// slot search
	logic [NUM_PORTS-1:0] prev_open;
	logic slot_found;
	port_idx_t slot_sel;

	// source search
	logic win_found;
	src_kind_t win_kind;
	port_idx_t win_idx;
	logic win_axis_x;
	slot_t new_slot;

	// lower slot must be filled or masked off first
	always_comb begin
		prev_open[0] = 1'b1;
		for (int y = 1; y < NUM_PORTS; y++)
			prev_open[y] = ~mask[y-1] | slots[y-1].active;
	end

	always_comb begin
		slot_found = 1'b0;
		slot_sel = '0;
		for (int y = 0; y < NUM_PORTS; y++) begin
			if (!slot_found && mask[y] && !slots[y].active && prev_open[y]) begin
				slot_found = 1'b1;
				slot_sel = port_idx_t'(y);
			end
		end
	end

	// lowest priority first, later hits override
	always_comb begin
		win_found = 1'b0;
		win_kind = SRC_SPINNER;
		win_idx = '0;
		win_axis_x = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (x_sel[i] && !x_used[i]) begin
				win_found = 1'b1;
				win_kind = SRC_ANALOG;
				win_idx = port_idx_t'(i);
				win_axis_x = 1'b1;
			end
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (y_sel[i] && !y_used[i]) begin
				win_found = 1'b1;
				win_kind = SRC_ANALOG;
				win_idx = port_idx_t'(i);
				win_axis_x = 1'b0;
			end
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (p_sel[i] && !p_used[i]) begin
				win_found = 1'b1;
				win_kind = SRC_SPINNER;
				win_idx = port_idx_t'(i);
				win_axis_x = 1'b0;
			end
		end
		// mouse is claimed by its button, not by motion
		if (mouse_button && !mouse_used) begin
			win_found = 1'b1;
			win_kind = SRC_MOUSE;
			win_idx = '0;
			win_axis_x = 1'b0;
		end
	end

	always_comb begin
		new_slot.active = 1'b1;
		new_slot.kind = win_kind;
		new_slot.idx = win_idx;
		new_slot.axis_x = win_axis_x;
		// y slot takes the alternate button only in multi mode
		new_slot.alt_btn = (win_kind == SRC_ANALOG) && !win_axis_x && use_multi;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			assigned <= '0;
			slots <= '0;
			x_used <= '0;
			y_used <= '0;
			p_used <= '0;
			mouse_used <= 1'b0;
		end else begin
			assigned <= '0;
			if (slot_found && win_found) begin
				assigned[slot_sel] <= 1'b1;
				slots[slot_sel] <= new_slot;
				case (win_kind)
					SRC_MOUSE: mouse_used <= 1'b1;
					SRC_SPINNER: p_used[win_idx] <= 1'b1;
					default: begin
						// without multi, one axis takes the whole stick
						x_used[win_idx] <= x_used[win_idx] | win_axis_x | ~use_multi;
						y_used[win_idx] <= y_used[win_idx] | ~win_axis_x | ~use_multi;
					end
				endcase
			end
		end
	end

	assign stick_x_used = x_used[0] | y_used[0];

endmodule

/* verilog/paddle_mux.sv */
// ------------------------------
// purely combinational
// inactive slots read as 0, button 0
// ------------------------------
`timescale 1ns/1ps

module paddle_mux (
	input paddle_pkg::slot_array_t slots,
	input paddle_pkg::stick_t [paddle_pkg::NUM_PORTS-1:0] analog,
	input paddle_pkg::paddle_t [paddle_pkg::NUM_PORTS-1:0] paddle,
	input logic signed [7:0] mouse_pos,
	input logic mouse_button,
	input logic stick_x_used,
	input logic [paddle_pkg::NUM_PORTS-1:0] buttons_in,
	input logic [paddle_pkg::NUM_PORTS-1:0] alt_b_in,
	output paddle_pkg::paddle_t [paddle_pkg::NUM_PORTS-1:0] pd_out,
	output paddle_pkg::src_kind_t [paddle_pkg::NUM_PORTS-1:0] paddle_type,
	output logic [paddle_pkg::NUM_PORTS-1:0] paddle_but
);
	import paddle_pkg::*;

	always_comb begin
		slot_t cur;
		logic [7:0] axis;
		for (int s = 0; s < NUM_PORTS; s++) begin
			cur = slots[s];
			axis = cur.axis_x ? analog[cur.idx].x : analog[cur.idx].y;
			pd_out[s] = '0;
			paddle_but[s] = 1'b0;
			paddle_type[s] = cur.kind;
			if (cur.active) begin
				// paddle values run opposite to the source, hence the inversion
				case (cur.kind)
					SRC_SPINNER: begin
						pd_out[s] = ~paddle[cur.idx];
						paddle_but[s] = buttons_in[cur.idx];
					end
					SRC_ANALOG: begin
						pd_out[s] = ~to_offset(axis);
						paddle_but[s] = cur.alt_btn ? alt_b_in[cur.idx] : buttons_in[cur.idx];
					end
					SRC_MOUSE: begin
						pd_out[s] = ~to_offset(mouse_pos);
						// joypad 0 fire shares the mouse slot until stick 0 is taken
						paddle_but[s] = mouse_button | (buttons_in[0] & ~stick_x_used);
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* verilog/paddle_chooser.sv */
// ------------------------------
// automatic paddle source chooser
// no calibration or rc timing here
// ------------------------------
`timescale 1ns/1ps

module paddle_chooser #(
	parameter int MOUSE_STEP_MAX = 64
) (
	input logic clk,
	input logic reset,
	input logic [paddle_pkg::NUM_PORTS-1:0] mask,
	input logic use_multi,
	input paddle_pkg::mouse_pkt_t mouse,
	input paddle_pkg::stick_t [paddle_pkg::NUM_PORTS-1:0] analog,
	input paddle_pkg::paddle_t [paddle_pkg::NUM_PORTS-1:0] paddle,
	input logic [paddle_pkg::NUM_PORTS-1:0] buttons_in,
	input logic [paddle_pkg::NUM_PORTS-1:0] alt_b_in,
	output logic [paddle_pkg::NUM_PORTS-1:0] assigned,
	output paddle_pkg::paddle_t [paddle_pkg::NUM_PORTS-1:0] pd_out,
	output paddle_pkg::src_kind_t [paddle_pkg::NUM_PORTS-1:0] paddle_type,
	output logic [paddle_pkg::NUM_PORTS-1:0] paddle_but
);
	import paddle_pkg::*;

	logic [NUM_PORTS-1:0] x_sel;
	logic [NUM_PORTS-1:0] y_sel;
	logic [NUM_PORTS-1:0] p_sel;
	slot_array_t slots;
	logic stick_x_used;
	logic signed [7:0] mouse_pos;

	motion_detect motion0 (.clk, .analog, .paddle, .x_sel, .y_sel, .p_sel);

	mouse_tracker #(.MOUSE_STEP_MAX(MOUSE_STEP_MAX)) mouse0 (.clk, .reset, .mouse, .mouse_pos);

	paddle_assigner assign0 (
		.clk, .reset, .mask, .use_multi, .mouse_button(mouse.button),
		.x_sel, .y_sel, .p_sel, .assigned, .slots, .stick_x_used
	);

	paddle_mux mux0 (
		.slots, .analog, .paddle, .mouse_pos, .mouse_button(mouse.button),
		.stick_x_used, .buttons_in, .alt_b_in, .pd_out, .paddle_type, .paddle_but
	);

endmodule

/* dv/paddle_chooser_props.sv */
// ------------------------------
// checks on the slot assigner
// all checks off while in reset
// ------------------------------
`timescale 1ns/1ps

module paddle_chooser_props (
	input logic clk,
	input logic reset,
	input logic [paddle_pkg::NUM_PORTS-1:0] mask,
	input logic [paddle_pkg::NUM_PORTS-1:0] assigned,
	input paddle_pkg::slot_array_t slots
);
	import paddle_pkg::*;

	// active bit of every slot
	logic [NUM_PORTS-1:0] active;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++)
			active[i] = slots[i].active;
	end

	claim_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(assigned))
		else $error("more than one slot claimed in one cycle");

	// claim decided on last cycle's mask
	claim_masked: assert property (@(posedge clk) disable iff (reset)
		(assigned & ~$past(mask)) == '0)
		else $error("slot claimed while masked off");

	active_holds: assert property (@(posedge clk) disable iff (reset)
		($past(active) & ~active) == '0)
		else $error("claimed slot dropped without reset");

endmodule

bind paddle_assigner paddle_chooser_props props0 (
	.clk(clk), .reset(reset), .mask(mask), .assigned(assigned), .slots(slots)
);

/* dv/paddle_chooser_tb.sv */
// ------------------------------
// directed tests, reset before each
// inputs change on the rising edge
// outputs sampled on the falling edge
// ------------------------------
`timescale 1ns/1ps

module paddle_chooser_tb;
	import paddle_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int STEP_MAX = 64;
	// six tests, each well under this many cycles including its resets
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 60;
	localparam int WATCHDOG_NS = (NUM_TESTS * CYCLES_PER_TEST + 100) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic [NUM_PORTS-1:0] mask;
	logic use_multi;
	mouse_pkt_t mouse;
	stick_t [NUM_PORTS-1:0] analog;
	paddle_t [NUM_PORTS-1:0] paddle;
	logic [NUM_PORTS-1:0] buttons_in;
	logic [NUM_PORTS-1:0] alt_b_in;
	logic [NUM_PORTS-1:0] assigned;
	paddle_t [NUM_PORTS-1:0] pd_out;
	src_kind_t [NUM_PORTS-1:0] paddle_type;
	logic [NUM_PORTS-1:0] paddle_but;

	int seed;
	int model_pos;   // reference mouse position
	int num_checks;

	paddle_chooser #(.MOUSE_STEP_MAX(STEP_MAX)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_paddle(input string name, input paddle_t exp, input paddle_t act);
		num_checks++;
		if (exp !== act)
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_kind(input string name, input src_kind_t exp, input src_kind_t act);
		num_checks++;
		if (exp !== act)
			abort_run($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_bits(input string name, input logic [NUM_PORTS-1:0] exp,
			input logic [NUM_PORTS-1:0] act);
		num_checks++;
		if (exp !== act)
			abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	// offset binary flips the top bit, the paddle value is then inverted
	function automatic paddle_t inv_offset(input logic [7:0] v);
		return {v[7], ~v[6:0]};
	endfunction

	// two's complement value whose offset form sits in the top or bottom quarter
	function automatic logic [7:0] extreme_axis(input logic [31:0] r);
		return {r[7], ~r[7], r[5:0]};
	endfunction

	// also parks every source at mid scale
	task automatic apply_reset(input logic [NUM_PORTS-1:0] mask_val, input logic multi);
		@(posedge clk);
		reset <= 1'b1;
		mask <= mask_val;
		use_multi <= multi;
		paddle <= {NUM_PORTS{8'h80}};
		analog <= '0;
		buttons_in <= '0;
		alt_b_in <= '0;
		mouse.button <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	// called in the step of the drive, assigned must pulse exactly at delay
	task automatic expect_claim(input string name, input int delay,
			input logic [NUM_PORTS-1:0] exp);
		for (int c = 1; c <= delay + 1; c++) begin
			@(posedge clk);
			@(negedge clk);
			check_bits(name, (c == delay) ? exp : '0, assigned);
		end
	endtask

	task automatic expect_no_claim(input string name, input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			@(negedge clk);
			check_bits(name, '0, assigned);
		end
	endtask

	// one packet, model updated from the step and wrap rules
	task automatic send_mouse(input string name, input logic sign, input logic [7:0] dx,
			input logic ovf);
		int step;
		step = sign ? int'(dx) - 256 : int'(dx);
		if (ovf)
			step = sign ? -STEP_MAX : STEP_MAX;
		else if (step > STEP_MAX)
			step = STEP_MAX;
		else if (step < -STEP_MAX)
			step = -STEP_MAX;
		model_pos = model_pos + step;
		if (model_pos > 127)
			model_pos = -128;
		else if (model_pos < -128)
			model_pos = 127;
		@(posedge clk);
		mouse.strobe <= ~mouse.strobe;
		mouse.sign_x <= sign;
		mouse.dx <= dx;
		mouse.ovf_x <= ovf;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_paddle(name, inv_offset(8'(model_pos)), pd_out[0]);
	endtask

	task automatic test_spinner_claim();
		apply_reset(4'b1111, 1'b0);
		@(posedge clk);
		paddle[2] <= 8'hC5;
		buttons_in <= 4'b0100;
		expect_claim("spinner_claim", 2, 4'b0001);
		check_kind("spinner_claim", SRC_SPINNER, paddle_type[0]);
		check_paddle("spinner_claim", ~8'hC5, pd_out[0]);
		check_bits("spinner_claim", 4'b0001, paddle_but);
		@(posedge clk);
		buttons_in <= 4'b0000;
		@(negedge clk);
		check_bits("spinner_claim", 4'b0000, paddle_but);
	endtask

	task automatic test_slot_order();
		apply_reset(4'b1011, 1'b0);
		@(posedge clk);
		paddle[0] <= 8'hF0;
		expect_claim("slot_order", 2, 4'b0001);
		@(posedge clk);
		paddle[1] <= 8'h10;
		expect_claim("slot_order", 2, 4'b0010);
		// top bits 01, not an end position
		@(posedge clk);
		paddle[3] <= 8'h40;
		expect_no_claim("slot_order", 6);
		@(posedge clk);
		paddle[3] <= 8'hE0;
		expect_claim("slot_order", 2, 4'b1000);
		@(posedge clk);
		buttons_in <= 4'b1111;
		@(negedge clk);
		check_paddle("slot_order", 8'h00, pd_out[2]);
		check_paddle("slot_order", ~8'hE0, pd_out[3]);
		check_kind("slot_order", SRC_SPINNER, paddle_type[3]);
		check_bits("slot_order", 4'b1011, paddle_but);
	endtask

	task automatic test_stick_axes();
		logic [31:0] r;
		logic [7:0] rx;
		logic [7:0] ry;
		apply_reset(4'b1111, 1'b0);
		r = $random(seed);
		ry = extreme_axis(r);
		r = $random(seed);
		rx = extreme_axis(r);
		@(posedge clk);
		analog[1].y <= ry;
		buttons_in <= 4'b0010;
		expect_claim("stick_single", 2, 4'b0001);
		check_kind("stick_single", SRC_ANALOG, paddle_type[0]);
		check_paddle("stick_single", inv_offset(ry), pd_out[0]);
		check_bits("stick_single", 4'b0001, paddle_but);
		// y took the whole stick
		@(posedge clk);
		analog[1].x <= rx;
		expect_no_claim("stick_single", 6);

		apply_reset(4'b1111, 1'b1);
		r = $random(seed);
		rx = extreme_axis(r);
		r = $random(seed);
		ry = extreme_axis(r);
		@(posedge clk);
		analog[1].x <= rx;
		expect_claim("stick_multi", 2, 4'b0001);
		@(posedge clk);
		analog[1].y <= ry;
		expect_claim("stick_multi", 2, 4'b0010);
		check_paddle("stick_multi", inv_offset(rx), pd_out[0]);
		check_paddle("stick_multi", inv_offset(ry), pd_out[1]);
		@(posedge clk);
		alt_b_in <= 4'b0010;
		buttons_in <= 4'b0000;
		@(negedge clk);
		check_bits("stick_multi", 4'b0010, paddle_but);
		@(posedge clk);
		alt_b_in <= 4'b0000;
		buttons_in <= 4'b0010;
		@(negedge clk);
		check_bits("stick_multi", 4'b0001, paddle_but);
	endtask

	task automatic test_mouse_motion();
		apply_reset(4'b1111, 1'b0);
		model_pos = 0;
		@(posedge clk);
		mouse.button <= 1'b1;
		expect_claim("mouse_motion", 1, 4'b0001);
		check_kind("mouse_motion", SRC_MOUSE, paddle_type[0]);
		check_bits("mouse_motion", 4'b0001, paddle_but);
		@(posedge clk);
		mouse.button <= 1'b0;
		@(negedge clk);
		check_paddle("mouse_motion", inv_offset(8'(model_pos)), pd_out[0]);
		send_mouse("mouse_clamp_pos", 1'b0, 8'd200, 1'b0);
		send_mouse("mouse_small", 1'b0, 8'd10, 1'b0);
		send_mouse("mouse_ovf_wrap", 1'b0, 8'd0, 1'b1);
		send_mouse("mouse_ovf_neg", 1'b1, 8'h00, 1'b1);
		send_mouse("mouse_small_neg", 1'b1, 8'hF6, 1'b0);
		send_mouse("mouse_clamp_neg", 1'b1, 8'h20, 1'b0);
	endtask

	task automatic test_mouse_button();
		apply_reset(4'b1111, 1'b0);
		@(posedge clk);
		mouse.button <= 1'b1;
		expect_claim("mouse_button", 1, 4'b0001);
		@(posedge clk);
		mouse.button <= 1'b0;
		buttons_in <= 4'b0001;
		@(negedge clk);
		check_bits("mouse_button", 4'b0001, paddle_but);
		// stick 0 taken, its fire now belongs to slot 1 only
		@(posedge clk);
		analog[0].y <= 8'h70;
		expect_claim("mouse_button", 2, 4'b0010);
		check_bits("mouse_button", 4'b0010, paddle_but);
	endtask

	task automatic test_reset_clears();
		apply_reset(4'b1111, 1'b0);
		@(posedge clk);
		paddle[1] <= 8'hD0;
		expect_claim("reset_clears", 2, 4'b0001);
		@(posedge clk);
		paddle[3] <= 8'h05;
		expect_claim("reset_clears", 2, 4'b0010);
		apply_reset(4'b1111, 1'b0);
		@(posedge clk);
		buttons_in <= 4'b1111;
		@(negedge clk);
		check_bits("reset_clears", 4'b0000, assigned);
		for (int s = 0; s < NUM_PORTS; s++)
			check_paddle("reset_clears", 8'h00, pd_out[s]);
		check_bits("reset_clears", 4'b0000, paddle_but);
		@(posedge clk);
		paddle[1] <= 8'h20;
		expect_claim("reset_clears", 2, 4'b0001);
		check_paddle("reset_clears", ~8'h20, pd_out[0]);
		check_kind("reset_clears", SRC_SPINNER, paddle_type[0]);
	endtask

	initial begin
		seed = 32'h2e33;
		model_pos = 0;
		num_checks = 0;
		reset = 1'b1;
		mask = '0;
		use_multi = 1'b0;
		mouse = '0;
		analog = '0;
		paddle = {NUM_PORTS{8'h80}};
		buttons_in = '0;
		alt_b_in = '0;
		test_spinner_claim();
		test_slot_order();
		test_stick_axes();
		test_mouse_motion();
		test_mouse_button();
		test_reset_clears();
		if (num_checks > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("no checks were run");
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

/* verilog.f */
verilog/paddle_pkg.sv
verilog/motion_detect.sv
verilog/mouse_tracker.sv
verilog/paddle_assigner.sv
verilog/paddle_mux.sv
verilog/paddle_chooser.sv
dv/paddle_chooser_props.sv
dv/paddle_chooser_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TB_TOP = paddle_chooser_tb
RTL_TOP = paddle_chooser
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
